//--- Bender.yml
package:
  name: execute_cluster

sources:
  - files:
      - source/execPkg.sv
      - source/alu.sv
      - source/forwardUnit.sv
      - source/executeStage.sv
      - source/idExReg.sv
      - source/exMemReg.sv
      - source/executeCluster.sv
  - target: test
    files:
      - dv/executeChecker.sv
      - dv/executeTb.sv

//--- build.f
source/execPkg.sv
source/alu.sv
source/forwardUnit.sv
source/executeStage.sv
source/idExReg.sv
source/exMemReg.sv
source/executeCluster.sv
dv/executeChecker.sv
dv/executeTb.sv

//--- dv/executeChecker.sv
`timescale 1ns/1ps
`default_nettype none

module executeChecker (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire logic               stall_i,
    input  wire execPkg::idExCtrl_t decCtrl_i,
    input  wire execPkg::idExData_t decData_i,
    input  wire integer             idx_i,
    input  wire execPkg::pcSrc_t    expPcSrc_i,
    input  wire execPkg::word_t     expAlu_i,
    input  wire execPkg::word_t     expWrite_i,
    input  wire execPkg::pcSrc_t    pcSrc_i,
    input  wire execPkg::word_t     pcTarget_i,
    input  wire logic               flushDecode_i,
    input  wire execPkg::exMem_t    exMem_i,
    output int                      errors_o,
    output int                      finished_o
);
    import execPkg::*;

    logic     started = 1'b0;
    logic     exValid = 1'b0;
    pcSrc_t   exPc;
    word_t    exTarget;
    word_t    exAlu;
    word_t    exWrite;
    regAddr_t exRd;
    logic     exRegWr;
    logic     exMemWr;
    int       exIdx;
    logic     memValid = 1'b0;
    word_t    memAlu;
    word_t    memWrite;
    regAddr_t memRd;
    logic     memRegWr;
    logic     memMemWr;
    int       memIdx;
    logic     redirect;
    logic     bad [0:255];
    int       squashed = 0;
    int       retired = 0;
    int       errors = 0;

    assign redirect   = exValid && !stall_i && (exPc != PC_PLUS4);
    assign errors_o   = errors;
    assign finished_o = squashed + retired;

    initial begin
        foreach (bad[i]) bad[i] = 1'b0;
    end

    task automatic checkVal(string name, word_t exp, word_t act, int idx);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
            if (idx >= 0) bad[idx] = 1'b1;
        end
    endtask

    // Reference pipeline, ID/EX holds under stall and squashes behind a redirect
    always @(posedge clk_i) begin
        started  <= 1'b1;
        if (rst_i) begin
            exValid  <= 1'b0;
            memValid <= 1'b0;
        end else begin
            memValid <= exValid && !stall_i;
            memAlu   <= exAlu;
            memWrite <= exWrite;
            memRd    <= exRd;
            memRegWr <= exRegWr;
            memMemWr <= exMemWr;
            memIdx   <= exIdx;
            if (!stall_i && redirect) begin
                exValid <= 1'b0;
                if (decCtrl_i.valid) begin
                    $display("entry %0d squashed behind redirect", idx_i);
                    squashed++;
                end
            end else if (!stall_i) begin
                exValid  <= decCtrl_i.valid;
                exPc     <= expPcSrc_i;
                exTarget <= decData_i.pc + decData_i.immExt;
                exAlu    <= expAlu_i;
                exWrite  <= expWrite_i;
                exRd     <= decData_i.rd;
                exRegWr  <= decCtrl_i.regWrite;
                exMemWr  <= decCtrl_i.memWrite;
                exIdx    <= idx_i;
            end
        end
    end

    // Outputs are settled mid-cycle
    always @(negedge clk_i) begin
        if (started) begin
            checkVal("pcSrc_o", word_t'(redirect ? exPc : PC_PLUS4), word_t'(pcSrc_i),
                     exValid ? exIdx : -1);
            checkVal("flushDecode_o", word_t'(redirect), word_t'(flushDecode_i),
                     exValid ? exIdx : -1);
            if (exValid) checkVal("pcTarget_o", exTarget, pcTarget_i, exIdx);
            checkVal("exMem_o.valid", word_t'(memValid), word_t'(exMem_i.valid),
                     memValid ? memIdx : -1);
            checkVal("exMem_o.regWrite", word_t'(memValid && memRegWr),
                     word_t'(exMem_i.regWrite), memValid ? memIdx : -1);
            checkVal("exMem_o.memWrite", word_t'(memValid && memMemWr),
                     word_t'(exMem_i.memWrite), memValid ? memIdx : -1);
            if (memValid) begin
                checkVal("exMem_o.aluResult", memAlu, exMem_i.aluResult, memIdx);
                checkVal("exMem_o.writeData", memWrite, exMem_i.writeData, memIdx);
                checkVal("exMem_o.rd", word_t'(memRd), word_t'(exMem_i.rd), memIdx);
                $display("entry %0d retired: %s", memIdx, bad[memIdx] ? "mismatch" : "ok");
                retired++;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/executeTb.sv
`timescale 1ns/1ps
`default_nettype none

module executeTb;
    import execPkg::*;

    typedef struct packed {
        idExCtrl_t ctrl;
        idExData_t data;
        wbFwd_t    wb;          // Bypass seen while this entry executes
        logic      stall;
        pcSrc_t    expPc;
        word_t     expAlu;
        word_t     expWrite;
    } entry_t;

    logic      clk_i = 1'b0;
    logic      rst_i = 1'b1;
    logic      stall_i = 1'b0;
    idExCtrl_t decCtrl_i = CTRL_BUBBLE;
    idExData_t decData_i = '0;
    wbFwd_t    wbFwd_i = '0;
    pcSrc_t    pcSrc_o;
    word_t     pcTarget_o;
    logic      flushDecode_o;
    exMem_t    exMem_o;
    int        idx = -1;
    pcSrc_t    expPc = PC_PLUS4;
    word_t     expAlu = '0;
    word_t     expWrite = '0;
    int        errors;
    int        finished;
    entry_t    tbl[$];
    int        validCount = 0;
    int        cycles = 0;
    int        limit = 1000;

    executeCluster dut (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall_i),
        .decCtrl_i(decCtrl_i), .decData_i(decData_i), .wbFwd_i(wbFwd_i),
        .pcSrc_o(pcSrc_o), .pcTarget_o(pcTarget_o),
        .flushDecode_o(flushDecode_o), .exMem_o(exMem_o)
    );

    executeChecker scoreboard (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall_i),
        .decCtrl_i(decCtrl_i), .decData_i(decData_i), .idx_i(idx),
        .expPcSrc_i(expPc), .expAlu_i(expAlu), .expWrite_i(expWrite),
        .pcSrc_i(pcSrc_o), .pcTarget_i(pcTarget_o), .flushDecode_i(flushDecode_o),
        .exMem_i(exMem_o), .errors_o(errors), .finished_o(finished)
    );

    initial begin
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: not all entries left the pipeline within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic word_t aluModel(aluOp_t op, word_t a, word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return word_t'($signed(a) < $signed(b));
            SLL:     return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    function automatic idExCtrl_t mkCtrl(jumpType_t j, logic br, aluOp_t op, logic src,
                                         logic rw);
        return '{jump: j, branch: br, aluCtrl: op, aluSrc: src, regWrite: rw,
                 memWrite: 1'b0, valid: 1'b1};
    endfunction

    function automatic idExData_t mkData(word_t a, word_t b, word_t imm, regAddr_t rs1,
                                         regAddr_t rs2, regAddr_t rd);
        return '{rd1: a, rd2: b, pc: $urandom & 32'hffff_fffc, immExt: imm,
                 rs1: rs1, rs2: rs2, rd: rd};
    endfunction

    task automatic addEntry(idExCtrl_t c, idExData_t d, wbFwd_t w, logic st, pcSrc_t p,
                            word_t alu, word_t wr);
        tbl.push_back('{ctrl: c, data: d, wb: w, stall: st, expPc: p, expAlu: alu,
                        expWrite: wr});
    endtask

    task automatic addVictim();
        addEntry(mkCtrl(BLT, 0, ADD, 0, 1), mkData(1, 2, 0, 0, 0, 3), '0, 0, PC_PLUS4, 3, 2);
    endtask

    task automatic addBranch(jumpType_t j, word_t a, word_t b, logic taken);
        idExData_t d;
        d = mkData(a, b, $urandom, 0, 0, 0);
        addEntry(mkCtrl(j, 1, SUB, 0, 0), d, '0, 0, taken ? PC_TARGET : PC_PLUS4, a - b, b);
        if (taken) addVictim();
    endtask

    task automatic buildTable();
        idExCtrl_t c;
        idExData_t d;
        word_t     a;
        word_t     b;
        for (int op = 0; op < 8; op++) begin
            a = $urandom;
            b = $urandom;
            d = mkData(a, b, $urandom, 0, 0, regAddr_t'(op + 1));
            addEntry(mkCtrl(BLT, 0, aluOp_t'(op), 0, 1), d, '0, 0, PC_PLUS4,
                     aluModel(aluOp_t'(op), a, b), b);
            addEntry(mkCtrl(BLT, 0, aluOp_t'(op), 1, 1), d, '0, 0, PC_PLUS4,
                     aluModel(aluOp_t'(op), a, d.immExt), b);
        end
        // Store with base plus offset
        a = $urandom;
        b = $urandom;
        c = mkCtrl(BLT, 0, ADD, 1, 0);
        c.memWrite = 1'b1;
        d = mkData(a, b, $urandom, 0, 0, 0);
        addEntry(c, d, '0, 0, PC_PLUS4, a + d.immExt, b);
        a = $urandom;
        addBranch(BEQ, a, a, 1);
        addBranch(BEQ, a, a + 1, 0);
        addBranch(BNE_JAL, a, a + 1, 1);
        addBranch(BNE_JAL, a, a, 0);
        addBranch(BLT, -5, 3, 1);
        addBranch(BLT, 3, -5, 0);
        d = mkData(a, 7, $urandom, 0, 0, 0);
        addEntry(mkCtrl(BNE_JAL, 0, ADD, 0, 0), d, '0, 0, PC_TARGET, a + 7, 7);
        addVictim();
        d = mkData(a, 7, $urandom, 0, 0, 0);
        addEntry(mkCtrl(JALR, 0, ADD, 1, 0), d, '0, 0, PC_ALU, a + d.immExt, 7);
        addVictim();
        // Back to back, then two apart, then both matching, then x0
        addEntry(mkCtrl(BLT, 0, ADD, 0, 1), mkData(10, 20, 0, 0, 0, 5), '0, 0, PC_PLUS4, 30, 20);
        addEntry(mkCtrl(BLT, 0, ADD, 0, 1), mkData(99, 4, 0, 5, 0, 6), '0, 0, PC_PLUS4, 34, 4);
        addEntry(mkCtrl(BLT, 0, ADD, 0, 1), mkData(1, 2, 0, 0, 0, 7), '0, 0, PC_PLUS4, 3, 2);
        addEntry(mkCtrl(BLT, 0, OR, 0, 0), mkData(0, 0, 0, 0, 0, 0), '0, 0, PC_PLUS4, 0, 0);
        addEntry(mkCtrl(BLT, 0, ADD, 0, 1), mkData(40, 55, 0, 0, 7, 8), '{3, 7, 1}, 0,
                 PC_PLUS4, 43, 3);
        addEntry(mkCtrl(BLT, 0, ADD, 0, 1), mkData(8, 9, 0, 0, 0, 9), '0, 0, PC_PLUS4, 17, 9);
        addEntry(mkCtrl(BLT, 0, ADD, 1, 1), mkData(66, 0, 100, 9, 0, 4), '{77, 9, 1}, 0,
                 PC_PLUS4, 117, 0);
        addEntry(mkCtrl(BLT, 0, ADD, 0, 1), mkData(5, 5, 0, 0, 0, 0), '0, 0, PC_PLUS4, 10, 5);
        addEntry(mkCtrl(BLT, 0, ADD, 1, 1), mkData(12, 0, 3, 0, 0, 2), '{88, 0, 1}, 0,
                 PC_PLUS4, 15, 0);
        // Held branch redirects only after release
        addEntry(mkCtrl(BEQ, 1, SUB, 0, 0), mkData(6, 6, 64, 0, 0, 0), '0, 0, PC_TARGET, 0, 6);
        addEntry(CTRL_BUBBLE, '0, '0, 1, PC_PLUS4, 0, 0);
        addEntry(CTRL_BUBBLE, '0, '0, 1, PC_PLUS4, 0, 0);
        addVictim();
        addEntry(CTRL_BUBBLE, '0, '0, 0, PC_PLUS4, 0, 0);
    endtask

    initial begin
        void'($urandom(32'h8c3d));
        buildTable();
        foreach (tbl[k]) if (tbl[k].ctrl.valid) validCount++;
        limit = tbl.size() + 20 + 3;
        repeat (3) @(posedge clk_i);
        #1 rst_i = 1'b0;
        foreach (tbl[k]) begin
            @(posedge clk_i);
            #1;
            decCtrl_i = tbl[k].ctrl;
            decData_i = tbl[k].data;
            stall_i   = tbl[k].stall;
            wbFwd_i   = (k > 0) ? tbl[k-1].wb : '0;   // Bypass lags issue by one cycle
            idx       = k;
            expPc     = tbl[k].expPc;
            expAlu    = tbl[k].expAlu;
            expWrite  = tbl[k].expWrite;
        end
        @(posedge clk_i);
        #1;
        decCtrl_i = CTRL_BUBBLE;
        stall_i   = 1'b0;
        wbFwd_i   = tbl[tbl.size()-1].wb;
        while (finished < validCount) @(posedge clk_i);
        repeat (2) @(posedge clk_i);
        $display("entries finished %0d of %0d, check errors %0d", finished, validCount, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire execPkg::word_t  srcA_i,
    input  wire execPkg::word_t  srcB_i,
    input  wire execPkg::aluOp_t aluCtrl_i,
    output execPkg::word_t       result_o,
    output execPkg::aluFlags_t   flags_o
);
    import execPkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lessThan;

    assign shamt    = srcB_i[SHAMT_W-1:0];              // Low bits of B only
    assign lessThan = $signed(srcA_i) < $signed(srcB_i);

    always_comb begin
        case (aluCtrl_i)
            ADD:     result_o = srcA_i + srcB_i;
            SUB:     result_o = srcA_i - srcB_i;
            AND:     result_o = srcA_i & srcB_i;
            OR:      result_o = srcA_i | srcB_i;
            XOR:     result_o = srcA_i ^ srcB_i;
            SLT:     result_o = {{(XLEN-1){1'b0}}, lessThan};
            SLL:     result_o = srcA_i << shamt;
            SRL:     result_o = srcA_i >> shamt;    // Logical, no sign fill
            default: result_o = '0;
        endcase
    end

    // Compare flags feed the branch decision in executeStage
    assign flags_o[FLAG_ZERO] = (result_o == '0);
    assign flags_o[FLAG_LT]   = lessThan;

endmodule

`default_nettype wire

//--- source/exMemReg.sv
`timescale 1ns/1ps
`default_nettype none

module exMemReg (
    input  wire logic            clk_i,
    input  wire logic            rst_i,
    input  wire logic            stall_i,
    input  wire execPkg::exMem_t entry_i,
    output execPkg::exMem_t      entry_o
);
    import execPkg::*;

    logic     validQ;
    logic     regWriteQ;
    logic     memWriteQ;
    word_t    aluResultQ;
    word_t    writeDataQ;
    regAddr_t rdQ;

    // A stalled cycle leaves a bubble so the held entry writes once
    always_ff @(posedge clk_i) begin
        if (rst_i || stall_i) begin
            validQ    <= 1'b0;
            regWriteQ <= 1'b0;
            memWriteQ <= 1'b0;
        end else begin
            validQ    <= entry_i.valid;
            regWriteQ <= entry_i.regWrite & entry_i.valid;  // No writes from a bubble
            memWriteQ <= entry_i.memWrite & entry_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        aluResultQ <= entry_i.aluResult;
        writeDataQ <= entry_i.writeData;
        rdQ        <= entry_i.rd;
    end

    assign entry_o = '{
        aluResult: aluResultQ,
        writeData: writeDataQ,
        rd:        rdQ,
        regWrite:  regWriteQ,
        memWrite:  memWriteQ,
        valid:     validQ
    };

endmodule

`default_nettype wire

//--- source/execPkg.sv
`default_nettype none

package execPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(XLEN);   // Shift amount bits
    localparam int FLAG_ZERO  = 0;              // Index into aluFlags_t
    localparam int FLAG_LT    = 1;              // Signed A < B

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;
    typedef logic [1:0]            aluFlags_t;

    typedef enum logic [2:0] {
        ADD = 3'b000,
        SUB = 3'b001,
        AND = 3'b010,
        OR  = 3'b011,
        XOR = 3'b100,
        SLT = 3'b101,
        SLL = 3'b110,
        SRL = 3'b111
    } aluOp_t;

    // Jump field as decode encodes it, BGE has no code of its own
    typedef enum logic [1:0] {
        BLT     = 2'b00,
        BNE_JAL = 2'b01,
        JALR    = 2'b10,
        BEQ     = 2'b11
    } jumpType_t;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_TARGET = 2'b01,
        PC_ALU    = 2'b10
    } pcSrc_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwdSel_t;

    typedef struct packed {
        jumpType_t jump;
        logic      branch;
        aluOp_t    aluCtrl;
        logic      aluSrc;      // Immediate as operand B
        logic      regWrite;
        logic      memWrite;
        logic      valid;
    } idExCtrl_t;

    typedef struct packed {
        word_t    rd1;
        word_t    rd2;
        word_t    pc;
        word_t    immExt;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
    } idExData_t;

    typedef struct packed {
        word_t    aluResult;
        word_t    writeData;
        regAddr_t rd;
        logic     regWrite;
        logic     memWrite;
        logic     valid;
    } exMem_t;

    typedef struct packed {
        word_t    result;
        regAddr_t rd;
        logic     regWrite;
    } wbFwd_t;

    localparam idExCtrl_t CTRL_BUBBLE = '{
        jump:     BLT,
        branch:   1'b0,
        aluCtrl:  ADD,
        aluSrc:   1'b0,
        regWrite: 1'b0,
        memWrite: 1'b0,
        valid:    1'b0
    };

endpackage

`default_nettype wire

//--- source/executeCluster.sv
`timescale 1ns/1ps
`default_nettype none

module executeCluster (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire logic               stall_i,
    input  wire execPkg::idExCtrl_t decCtrl_i,
    input  wire execPkg::idExData_t decData_i,
    input  wire execPkg::wbFwd_t    wbFwd_i,
    output execPkg::pcSrc_t         pcSrc_o,
    output execPkg::word_t          pcTarget_o,
    output logic                    flushDecode_o,
    output execPkg::exMem_t         exMem_o
);
    import execPkg::*;

    idExCtrl_t idExCtrl;
    idExData_t idExData;
    word_t     srcA;
    word_t     rs2Val;
    word_t     aluResult;
    word_t     writeData;
    exMem_t    exMemNext;

    // Redirect kills the instruction now sitting in decode
    assign flushDecode_o = idExCtrl.valid && (pcSrc_o != PC_PLUS4);

    idExReg idExStage (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .flush_i   (flushDecode_o),
        .decCtrl_i (decCtrl_i),
        .decData_i (decData_i),
        .ctrl_o    (idExCtrl),
        .data_o    (idExData)
    );

    forwardUnit fwd (
        .rs1_i    (idExData.rs1),
        .rs2_i    (idExData.rs2),
        .rd1_i    (idExData.rd1),
        .rd2_i    (idExData.rd2),
        .exMem_i  (exMem_o),                // Previous instruction's result
        .wbFwd_i  (wbFwd_i),
        .srcA_o   (srcA),
        .rs2Val_o (rs2Val)
    );

    executeStage exec (
        .ctrl_i      (idExCtrl),
        .pc_i        (idExData.pc),
        .immExt_i    (idExData.immExt),
        .srcA_i      (srcA),
        .rs2Val_i    (rs2Val),
        .stall_i     (stall_i),
        .pcTarget_o  (pcTarget_o),
        .aluResult_o (aluResult),
        .writeData_o (writeData),
        .pcSrc_o     (pcSrc_o)
    );

    assign exMemNext = '{
        aluResult: aluResult,
        writeData: writeData,
        rd:        idExData.rd,
        regWrite:  idExCtrl.regWrite,
        memWrite:  idExCtrl.memWrite,
        valid:     idExCtrl.valid
    };

    exMemReg exMemStage (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .entry_i (exMemNext),
        .entry_o (exMem_o)
    );

endmodule

`default_nettype wire

//--- source/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire execPkg::idExCtrl_t ctrl_i,
    input  wire execPkg::word_t     pc_i,
    input  wire execPkg::word_t     immExt_i,
    input  wire execPkg::word_t     srcA_i,
    input  wire execPkg::word_t     rs2Val_i,
    input  wire logic               stall_i,
    output execPkg::word_t          pcTarget_o,
    output execPkg::word_t          aluResult_o,
    output execPkg::word_t          writeData_o,
    output execPkg::pcSrc_t         pcSrc_o
);
    import execPkg::*;

    word_t     srcB;
    aluFlags_t flags;
    logic      zero;
    logic      less;
    pcSrc_t    decision;

    assign srcB        = ctrl_i.aluSrc ? immExt_i : rs2Val_i;
    assign pcTarget_o  = pc_i + immExt_i;       // Branch and JAL target
    assign writeData_o = rs2Val_i;              // Forwarded store data

    assign zero = flags[FLAG_ZERO];
    assign less = flags[FLAG_LT];

    alu aluUnit (
        .srcA_i    (srcA_i),
        .srcB_i    (srcB),
        .aluCtrl_i (ctrl_i.aluCtrl),
        .result_o  (aluResult_o),
        .flags_o   (flags)
    );

    // Jump and branch table, branch bit picks between the pair
    always_comb begin
        decision = PC_PLUS4;
        case (ctrl_i.jump)
            BLT: begin
                if (ctrl_i.branch && less) begin
                    decision = PC_TARGET;
                end
            end
            BNE_JAL: begin
                if (!ctrl_i.branch) begin
                    decision = PC_TARGET;           // JAL
                end else if (!zero) begin
                    decision = PC_TARGET;           // BNE taken
                end
            end
            JALR: begin
                if (!ctrl_i.branch) begin
                    decision = PC_ALU;              // rs1 + imm from the ALU
                end
            end
            BEQ: begin
                if (ctrl_i.branch && zero) begin
                    decision = PC_TARGET;
                end
            end
            default: decision = PC_PLUS4;
        endcase
    end

    // A held entry redirects only once, after release
    assign pcSrc_o = (ctrl_i.valid && !stall_i) ? decision : PC_PLUS4;

endmodule

`default_nettype wire

//--- source/forwardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
    input  wire execPkg::regAddr_t rs1_i,
    input  wire execPkg::regAddr_t rs2_i,
    input  wire execPkg::word_t    rd1_i,
    input  wire execPkg::word_t    rd2_i,
    input  wire execPkg::exMem_t   exMem_i,
    input  wire execPkg::wbFwd_t   wbFwd_i,
    output execPkg::word_t         srcA_o,
    output execPkg::word_t         rs2Val_o
);
    import execPkg::*;

    fwdSel_t selA;
    fwdSel_t selB;

    // Memory stage wins over writeback, x0 is never forwarded
    function automatic fwdSel_t pickSource(regAddr_t rs, exMem_t mem, wbFwd_t wb);
        fwdSel_t sel;
        sel = FWD_NONE;
        if (rs != '0) begin
            if (mem.valid && mem.regWrite && (mem.rd == rs)) begin
                sel = FWD_MEM;
            end else if (wb.regWrite && (wb.rd == rs)) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    function automatic word_t muxSource(fwdSel_t sel, word_t regVal, word_t memVal,
                                        word_t wbVal);
        word_t val;
        case (sel)
            FWD_MEM: val = memVal;
            FWD_WB:  val = wbVal;
            default: val = regVal;
        endcase
        return val;
    endfunction

    assign selA = pickSource(rs1_i, exMem_i, wbFwd_i);
    assign selB = pickSource(rs2_i, exMem_i, wbFwd_i);

    assign srcA_o   = muxSource(selA, rd1_i, exMem_i.aluResult, wbFwd_i.result);
    assign rs2Val_o = muxSource(selB, rd2_i, exMem_i.aluResult, wbFwd_i.result);

endmodule

`default_nettype wire

//--- source/idExReg.sv
`timescale 1ns/1ps
`default_nettype none

module idExReg (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire logic               stall_i,
    input  wire logic               flush_i,
    input  wire execPkg::idExCtrl_t decCtrl_i,
    input  wire execPkg::idExData_t decData_i,
    output execPkg::idExCtrl_t      ctrl_o,
    output execPkg::idExData_t      data_o
);
    import execPkg::*;

    idExCtrl_t ctrlQ;
    idExData_t dataQ;

    // Control half, stall checked before flush
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrlQ <= CTRL_BUBBLE;
        end else if (stall_i) begin
            ctrlQ <= ctrlQ;                 // Hold the waiting instruction
        end else if (flush_i) begin
            ctrlQ <= CTRL_BUBBLE;           // Squash the wrong-path slot
        end else begin
            ctrlQ <= decCtrl_i;
        end
    end

    // Operands and indices, meaningless while valid is low
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dataQ <= decData_i;
        end
    end

    assign ctrl_o = ctrlQ;
    assign data_o = dataQ;

    // executeStage gates its redirect under stall, so the two never meet
    noFlushUnderStall: assert property (
        @(posedge clk_i) disable iff (rst_i)
        stall_i |-> !flush_i
    ) else $error("idExReg: flush raised while stalled");

endmodule

`default_nettype wire
